/* Bender.yml */
package:
  name: banked_mem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/banked_mem_pkg.sv
      - hw/mem_bank.sv
      - hw/bank_router.sv
      - hw/apb_port_ctrl.sv
      - hw/banked_mem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/banked_mem_assertions.sv
      - testbench/tb_banked_mem.sv

/* build.f */
+incdir+include
hw/banked_mem_pkg.sv
hw/mem_bank.sv
hw/bank_router.sv
hw/apb_port_ctrl.sv
hw/banked_mem_top.sv
testbench/banked_mem_assertions.sv
testbench/tb_banked_mem.sv

/* hw/apb_port_ctrl.sv */
`timescale 1ns/1ns
`include "banked_mem_defines.svh"

module apb_port_ctrl (
	input  logic                     CLK,
	input  logic                     rst_n,
	input  banked_mem_pkg::apb_req_t apb_req,
	output banked_mem_pkg::apb_rsp_t apb_rsp,
	output banked_mem_pkg::mem_req_t mem_req,
	input  banked_mem_pkg::mem_rsp_t mem_rsp
);
	import banked_mem_pkg::*;

	apb_state_e state;
	apb_state_e state_next;
	mem_op_e    op;
	logic       setup;
	logic       access;
	logic       write_done;
	logic       read_done;
	logic       done;

	assign op = apb_req.pwrite ? OP_WRITE : OP_READ;

	assign setup = apb_req.psel && !apb_req.penable;
	assign access = apb_req.psel && apb_req.penable;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (setup) begin
					state_next = ST_ACCESS;
				end
			end
			ST_ACCESS: begin
				// a master that leaves the access phase early just drops the transfer
				if (!access) begin
					state_next = ST_IDLE;
				end else if (op == OP_WRITE) begin
					state_next = ST_IDLE;
				end else begin
					state_next = ST_READ_WAIT;
				end
			end
			ST_READ_WAIT: begin
				state_next = ST_IDLE;
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	// exactly one request per transfer, in the first access cycle
	always_comb begin
		mem_req.valid = (state == ST_ACCESS) && access;
		mem_req.op = op;
		mem_req.addr = apb_req.paddr;
		mem_req.wdata = apb_req.pwdata;
	end

	// writes finish with no wait state, reads after the bank's one-cycle latency
	assign write_done = (state == ST_ACCESS) && access && (op == OP_WRITE);
	assign read_done = (state == ST_READ_WAIT);
	assign done = write_done || read_done;

	always_comb begin
		apb_rsp.pready = done;
		apb_rsp.pslverr = done && mem_rsp.addr_err;
		if (read_done) begin
			apb_rsp.prdata = mem_rsp.rdata;
		end else begin
			apb_rsp.prdata = '0;
		end
	end

endmodule

/* hw/bank_router.sv */
`timescale 1ns/1ns
`include "banked_mem_defines.svh"

module bank_router (
	input  logic                     CLK,
	input  logic                     rst_n,
	input  banked_mem_pkg::mem_req_t req,
	output banked_mem_pkg::mem_rsp_t rsp,
	output logic [`MEM_NUM_BANKS-1:0] bank_we,
	output logic [`MEM_BANK_AW-1:0]  bank_addr,
	output logic [`MEM_WORD_W-1:0]   bank_wdata,
	input  logic [`MEM_WORD_W-1:0]   bank_rdata [`MEM_NUM_BANKS]
);
	import banked_mem_pkg::*;

	logic [`MEM_SEL_W-1:0] sel;
	logic [`MEM_SEL_W-1:0] sel_q;
	logic                  addr_err;
	logic                  err_q;

	assign sel = req.addr[`MEM_ADDR_W-1:`MEM_BANK_AW];
	assign addr_err = (sel >= `MEM_NUM_BANKS);

	// every bank sees the same address and data, only the enable is decoded
	assign bank_addr = req.addr[`MEM_BANK_AW-1:0];
	assign bank_wdata = req.wdata;

	always_comb begin
		bank_we = '0;
		if (req.valid && req.op == OP_WRITE && !addr_err) begin
			bank_we[sel] = 1'b1;
		end
	end

	// select and error follow the bank read by one cycle
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			err_q <= 1'b0;
		end else begin
			err_q <= addr_err;
		end
	end

	always_ff @(posedge CLK) begin
		sel_q <= sel;
	end

	// while a request is being issued the error belongs to it, which is what a
	// write completes with; a read completes a cycle later against err_q
	always_comb begin
		rsp.addr_err = req.valid ? addr_err : err_q;
		if (err_q) begin
			rsp.rdata = '0;
		end else begin
			rsp.rdata = bank_rdata[sel_q];
		end
	end

endmodule

/* hw/banked_mem_pkg.sv */
`include "banked_mem_defines.svh"

package banked_mem_pkg;

	// transfer kind, taken straight from pwrite
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} mem_op_e;

	typedef enum logic [1:0] {
		ST_IDLE      = 2'd0,
		ST_ACCESS    = 2'd1,
		ST_READ_WAIT = 2'd2
	} apb_state_e;

	typedef struct packed {
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [`MEM_ADDR_W-1:0] paddr;
		logic [`MEM_WORD_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic                   pready;
		logic                   pslverr;
		logic [`MEM_WORD_W-1:0] prdata;
	} apb_rsp_t;

	// one request per transfer, issued in the first access cycle
	typedef struct packed {
		logic                   valid;
		mem_op_e                op;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_WORD_W-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic                   addr_err;
		logic [`MEM_WORD_W-1:0] rdata;
	} mem_rsp_t;

endpackage

/* hw/banked_mem_top.sv */
`timescale 1ns/1ns
`include "banked_mem_defines.svh"

module banked_mem_top (
	input  logic                     CLK,
	input  logic                     rst_n,
	input  banked_mem_pkg::apb_req_t apb0_req,
	output banked_mem_pkg::apb_rsp_t apb0_rsp,
	input  banked_mem_pkg::apb_req_t apb1_req,
	output banked_mem_pkg::apb_rsp_t apb1_rsp
);
	import banked_mem_pkg::*;

	mem_req_t mem_req0;
	mem_req_t mem_req1;
	mem_rsp_t mem_rsp0;
	mem_rsp_t mem_rsp1;

	logic [`MEM_NUM_BANKS-1:0] bank_we0;
	logic [`MEM_NUM_BANKS-1:0] bank_we1;
	logic [`MEM_BANK_AW-1:0]   bank_addr0;
	logic [`MEM_BANK_AW-1:0]   bank_addr1;
	logic [`MEM_WORD_W-1:0]    bank_wdata0;
	logic [`MEM_WORD_W-1:0]    bank_wdata1;
	logic [`MEM_WORD_W-1:0]    bank_rdata0 [`MEM_NUM_BANKS];
	logic [`MEM_WORD_W-1:0]    bank_rdata1 [`MEM_NUM_BANKS];

	apb_port_ctrl u_ctrl0 (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.apb_req (apb0_req),
		.apb_rsp (apb0_rsp),
		.mem_req (mem_req0),
		.mem_rsp (mem_rsp0)
	);

	apb_port_ctrl u_ctrl1 (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.apb_req (apb1_req),
		.apb_rsp (apb1_rsp),
		.mem_req (mem_req1),
		.mem_rsp (mem_rsp1)
	);

	// port 0 owns side a of every bank, port 1 owns side b
	bank_router u_router0 (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.req        (mem_req0),
		.rsp        (mem_rsp0),
		.bank_we    (bank_we0),
		.bank_addr  (bank_addr0),
		.bank_wdata (bank_wdata0),
		.bank_rdata (bank_rdata0)
	);

	bank_router u_router1 (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.req        (mem_req1),
		.rsp        (mem_rsp1),
		.bank_we    (bank_we1),
		.bank_addr  (bank_addr1),
		.bank_wdata (bank_wdata1),
		.bank_rdata (bank_rdata1)
	);

	for (genvar i = 0; i < `MEM_NUM_BANKS; i++) begin : g_bank
		mem_bank u_bank (
			.CLK     (CLK),
			.we_a    (bank_we0[i]),
			.addr_a  (bank_addr0),
			.wdata_a (bank_wdata0),
			.rdata_a (bank_rdata0[i]),
			.we_b    (bank_we1[i]),
			.addr_b  (bank_addr1),
			.wdata_b (bank_wdata1),
			.rdata_b (bank_rdata1[i])
		);
	end

endmodule

/* hw/mem_bank.sv */
`timescale 1ns/1ns
`include "banked_mem_defines.svh"

module mem_bank (
	input  logic                    CLK,
	input  logic                    we_a,
	input  logic [`MEM_BANK_AW-1:0] addr_a,
	input  logic [`MEM_WORD_W-1:0]  wdata_a,
	output logic [`MEM_WORD_W-1:0]  rdata_a,
	input  logic                    we_b,
	input  logic [`MEM_BANK_AW-1:0] addr_b,
	input  logic [`MEM_WORD_W-1:0]  wdata_b,
	output logic [`MEM_WORD_W-1:0]  rdata_b
);

	logic [`MEM_WORD_W-1:0] mem [`MEM_BANK_DEPTH];

	// true dual port with one cycle of read latency on each side
	// a write leaves that side's read register holding its previous word
	always_ff @(posedge CLK) begin
		if (we_a) begin
			mem[addr_a] <= wdata_a;
		end else begin
			rdata_a <= mem[addr_a];
		end

		// same-word writes from both sides in one cycle are not defined,
		// here side b lands last
		if (we_b) begin
			mem[addr_b] <= wdata_b;
		end else begin
			rdata_b <= mem[addr_b];
		end
	end

endmodule

/* include/banked_mem_defines.svh */
`ifndef BANKED_MEM_DEFINES_SVH
`define BANKED_MEM_DEFINES_SVH

// width of one stored word
`define MEM_WORD_W 18

// word address inside a single bank
`define MEM_BANK_AW 10

`define MEM_BANK_DEPTH 1024

// thirty banks populate a 32-entry select space, so indices 30 and 31 are holes
`define MEM_NUM_BANKS 30

// upper address bits pick the bank
`define MEM_SEL_W 5

// full word address, bank select on top of the in-bank address
`define MEM_ADDR_W 15

`endif

/* testbench/banked_mem_assertions.sv */
`timescale 1ns/1ns
`include "banked_mem_defines.svh"

module banked_mem_checker (
	input logic                     CLK,
	input logic                     rst_n,
	input banked_mem_pkg::apb_req_t apb0_req,
	input banked_mem_pkg::apb_rsp_t apb0_rsp,
	input banked_mem_pkg::apb_req_t apb1_req,
	input banked_mem_pkg::apb_rsp_t apb1_rsp
);
	import banked_mem_pkg::*;

	int unsigned fail_count = 0;

	// shadow copy of the whole address space, with a flag for words written so far
	logic [`MEM_WORD_W-1:0] shadow [2**`MEM_ADDR_W];
	logic                   known [2**`MEM_ADDR_W];

	apb_req_t               req [2];
	apb_rsp_t               rsp [2];
	logic                   setup [2];
	logic                   access [2];
	logic                   done [2];
	logic                   in_range [2];
	logic [`MEM_WORD_W-1:0] expect_data [2];
	logic                   expect_known [2];

	assign req[0] = apb0_req;
	assign req[1] = apb1_req;
	assign rsp[0] = apb0_rsp;
	assign rsp[1] = apb1_rsp;

	initial begin
		for (int i = 0; i < 2**`MEM_ADDR_W; i++) begin
			known[i] = 1'b0;
		end
	end

	// only in-range writes land, whatever the DUT reports
	always @(posedge CLK) begin
		for (int p = 0; p < 2; p++) begin
			if (rst_n && done[p] && req[p].pwrite && in_range[p]) begin
				shadow[req[p].paddr] <= req[p].pwdata;
				known[req[p].paddr] <= 1'b1;
			end
		end
	end

	for (genvar p = 0; p < 2; p++) begin : g_port
		assign setup[p] = req[p].psel && !req[p].penable;
		assign access[p] = req[p].psel && req[p].penable;
		assign done[p] = access[p] && rsp[p].pready;
		assign in_range[p] = (req[p].paddr[`MEM_ADDR_W-1:`MEM_BANK_AW] < `MEM_NUM_BANKS);
		assign expect_data[p] = shadow[req[p].paddr];
		assign expect_known[p] = known[req[p].paddr];

		// outside an access cycle the slave stays silent
		a_quiet: assert property (@(posedge CLK) disable iff (!rst_n)
			!access[p] |-> !rsp[p].pready && !rsp[p].pslverr)
		else begin
			fail_count++;
			$error("ERROR %0t apb%0d_rsp pready/pslverr expected 0/0 actual %b/%b", $time, p,
				$sampled(rsp[p].pready), $sampled(rsp[p].pslverr));
		end

		a_write_timing: assert property (@(posedge CLK) disable iff (!rst_n)
			setup[p] ##1 (access[p] && req[p].pwrite) |-> rsp[p].pready)
		else begin
			fail_count++;
			$error("ERROR %0t apb%0d_rsp.pready expected 1 actual %b in first write access",
				$time, p, $sampled(rsp[p].pready));
		end

		a_read_timing: assert property (@(posedge CLK) disable iff (!rst_n)
			setup[p] ##1 (access[p] && !req[p].pwrite) |-> !rsp[p].pready ##1 rsp[p].pready)
		else begin
			fail_count++;
			$error("ERROR %0t apb%0d_rsp.pready expected 0 then 1 over the read access actual %b",
				$time, p, $sampled(rsp[p].pready));
		end

		a_slverr: assert property (@(posedge CLK) disable iff (!rst_n)
			done[p] |-> rsp[p].pslverr == !in_range[p])
		else begin
			fail_count++;
			$error("ERROR %0t apb%0d_rsp.pslverr expected %b actual %b", $time, p,
				!$sampled(in_range[p]), $sampled(rsp[p].pslverr));
		end

		a_read_data: assert property (@(posedge CLK) disable iff (!rst_n)
			done[p] && !req[p].pwrite && in_range[p] && expect_known[p]
			|-> rsp[p].prdata == expect_data[p])
		else begin
			fail_count++;
			$error("ERROR %0t apb%0d_rsp.prdata expected %h actual %h", $time, p,
				$sampled(expect_data[p]), $sampled(rsp[p].prdata));
		end

		a_error_data: assert property (@(posedge CLK) disable iff (!rst_n)
			done[p] && !req[p].pwrite && !in_range[p] |-> rsp[p].prdata == '0)
		else begin
			fail_count++;
			$error("ERROR %0t apb%0d_rsp.prdata expected 0 actual %h", $time, p,
				$sampled(rsp[p].prdata));
		end
	end

endmodule

bind banked_mem_top banked_mem_checker u_checker (
	.CLK      (CLK),
	.rst_n    (rst_n),
	.apb0_req (apb0_req),
	.apb0_rsp (apb0_rsp),
	.apb1_req (apb1_req),
	.apb1_rsp (apb1_rsp)
);

/* testbench/tb_banked_mem.sv */
`timescale 1ns/1ns
`include "banked_mem_defines.svh"

module tb_banked_mem;
	import banked_mem_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_RANDOM = 160;
	localparam int NUM_CONCURRENT = 20;
	localparam int PLANNED_XFERS = 2 * `MEM_NUM_BANKS + NUM_RANDOM + 4 * NUM_CONCURRENT + 12;
	localparam int READY_LIMIT = 8;

	logic        CLK;
	logic        rst_n;
	apb_req_t    req_drv [2];
	apb_rsp_t    rsp_mon [2];
	int unsigned xfer_count = 0;
	int unsigned tb_errors = 0;
	int unsigned total_errors;

	logic [`MEM_ADDR_W-1:0] written_q [$];

	banked_mem_top UUT (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.apb0_req (req_drv[0]),
		.apb0_rsp (rsp_mon[0]),
		.apb1_req (req_drv[1]),
		.apb1_rsp (rsp_mon[1])
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	function automatic logic [`MEM_WORD_W-1:0] rand_word();
		rand_word = `MEM_WORD_W'($urandom);
	endfunction

	function automatic logic [`MEM_ADDR_W-1:0] bank_addr(input int bank);
		logic [`MEM_SEL_W-1:0]   sel;
		logic [`MEM_BANK_AW-1:0] word;
		sel = `MEM_SEL_W'(bank);
		word = `MEM_BANK_AW'($urandom);
		bank_addr = {sel, word};
	endfunction

	function automatic logic [`MEM_ADDR_W-1:0] pick_written();
		pick_written = written_q[$urandom % written_q.size()];
	endfunction

	// setup on one falling edge, access on the next, held until pready is seen
	task automatic apb_transfer(input int port, input logic write,
			input logic [`MEM_ADDR_W-1:0] addr, input logic [`MEM_WORD_W-1:0] data);
		int waited;
		waited = 0;
		@(negedge CLK);
		req_drv[port].psel = 1'b1;
		req_drv[port].penable = 1'b0;
		req_drv[port].pwrite = write;
		req_drv[port].paddr = addr;
		req_drv[port].pwdata = data;
		@(negedge CLK);
		req_drv[port].penable = 1'b1;
		#(CLK_PERIOD / 4);
		while (!rsp_mon[port].pready) begin
			waited++;
			if (waited > READY_LIMIT) begin
				$display("port %0d got no pready for the transfer at address %h", port, addr);
				tb_errors++;
				break;
			end
			@(negedge CLK);
			#(CLK_PERIOD / 4);
		end
		@(negedge CLK);
		req_drv[port].psel = 1'b0;
		req_drv[port].penable = 1'b0;
		xfer_count++;
		if (write && addr[`MEM_ADDR_W-1:`MEM_BANK_AW] < `MEM_NUM_BANKS) begin
			written_q.push_back(addr);
		end
	endtask

	initial begin
		#(CLK_PERIOD * (PLANNED_XFERS * 4 + 100));
		$display("watchdog expired after %0d transfers, the DUT stopped responding", xfer_count);
		$display("Checks failed");
		$finish;
	end

	initial begin
		logic [`MEM_ADDR_W-1:0] addr_a;
		logic [`MEM_ADDR_W-1:0] addr_b;
		logic [`MEM_ADDR_W-1:0] base;
		int                     port;

		void'($urandom(32'h1063_7642));
		rst_n = 1'b0;
		req_drv[0] = '0;
		req_drv[1] = '0;
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		rst_n = 1'b1;
		// a few idle cycles with nothing on either bus
		repeat (3) @(negedge CLK);

		// one word in every bank, read back through the other port
		for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
			apb_transfer(b % 2, 1'b1, bank_addr(b), rand_word());
		end
		for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
			apb_transfer((b + 1) % 2, 1'b0, written_q[b], '0);
		end

		for (int i = 0; i < NUM_RANDOM; i++) begin
			port = $urandom % 2;
			if ($urandom % 2) begin
				apb_transfer(port, 1'b1, bank_addr($urandom % `MEM_NUM_BANKS), rand_word());
			end else begin
				apb_transfer(port, 1'b0, pick_written(), '0);
			end
		end

		// both ports busy at once, always on different words
		for (int i = 0; i < NUM_CONCURRENT; i++) begin
			addr_a = bank_addr($urandom % `MEM_NUM_BANKS);
			do begin
				addr_b = bank_addr($urandom % `MEM_NUM_BANKS);
			end while (addr_b == addr_a);
			fork
				apb_transfer(0, 1'b1, addr_a, rand_word());
				apb_transfer(1, 1'b1, addr_b, rand_word());
			join
			fork
				apb_transfer(0, 1'b0, addr_b, '0);
				apb_transfer(1, 1'b0, addr_a, '0);
			join
		end

		// missing banks share the in-bank word with a written address
		for (int p = 0; p < 2; p++) begin
			for (int sel = `MEM_NUM_BANKS; sel < 32; sel++) begin
				base = pick_written();
				addr_a = {`MEM_SEL_W'(sel), base[`MEM_BANK_AW-1:0]};
				apb_transfer(p, 1'b1, addr_a, rand_word());
				apb_transfer(p, 1'b0, addr_a, '0);
				apb_transfer(p, 1'b0, base, '0);
			end
		end

		repeat (3) @(negedge CLK);
		total_errors = UUT.u_checker.fail_count + tb_errors;
		$display("transfers %0d, errors %0d", xfer_count, total_errors);
		if (total_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
